// ==== common/trig_csr_pkg.sv ====
// Trigger CSR map and configuration layout for the breakpoint unit.
// Only mcontrol (type 2) execute triggers exist, exact match only.
// N_TRIGGERS must be at least one. tselect is sized from it, and values
// past the last trigger read back as a trigger of type 0.

package trig_csr_pkg;

	// ----------------------------------------------------------
	// sizes

	// number of breakpoint triggers
	localparam int N_TRIGGERS = 4;
	// tselect width, kept at one bit for a single trigger
	localparam int W_TSELECT = (N_TRIGGERS > 1) ? $clog2(N_TRIGGERS) : 1;
	localparam int W_DATA = 32;

	// ----------------------------------------------------------
	// csr addresses

	typedef enum logic [11:0] {
		CSR_TSELECT = 12'h7a0,
		CSR_TDATA1  = 12'h7a1,
		CSR_TDATA2  = 12'h7a2,
		CSR_TINFO   = 12'h7a4
	} csr_addr_e;

	// tdata1 (mcontrol) bit positions
	localparam int TD1_TYPE_LSB = 28;
	localparam int TD1_DMODE    = 27;
	// action is 4 bits wide, only its lsb is kept
	localparam int TD1_ACTION   = 12;
	localparam int TD1_M        = 6;
	localparam int TD1_U        = 3;
	localparam int TD1_EXECUTE  = 2;

	// tinfo values, one-hot type mask
	localparam logic [W_DATA-1:0] TINFO_NONE     = 32'd1;
	localparam logic [W_DATA-1:0] TINFO_MCONTROL = 32'd4;

	// ----------------------------------------------------------
	// structs

	// csr access from the execute stage
	typedef struct packed {
		logic [11:0]       addr;
		logic              wen;
		logic [W_DATA-1:0] wdata;
	} csr_req_t;

	// stored state of one trigger
	typedef struct packed {
		logic              execute;
		logic              m;
		logic              u;
		// 1: break to debug mode, 0: breakpoint exception
		logic              action;
		// trigger owned by debug mode
		logic              dmode;
		logic [W_DATA-1:0] tdata2;
	} trig_cfg_t;

endpackage

// ==== common/trig_fetch_pkg.sv ====
// Fetch-side types for the breakpoint unit.
// Fetches are always one word, word aligned. A break is reported for
// each halfword on its own, since instruction boundaries are unknown
// until the fetch data returns.

package trig_fetch_pkg;

	localparam int W_ADDR = 32;

	// ----------------------------------------------------------
	// privilege of a fetch or of the execute stage

	// debug mode gets its own code and is not a real riscv level
	typedef enum logic [1:0] {
		PRIV_U = 2'b00,
		PRIV_D = 2'b10,
		PRIV_M = 2'b11
	} priv_e;

	// ----------------------------------------------------------
	// structs

	// address-phase fetch query, no back-pressure
	typedef struct packed {
		logic              valid;
		// low two bits expected zero
		logic [W_ADDR-1:0] addr;
		priv_e             priv;
	} fetch_req_t;

	// break flags for one fetch word
	typedef struct packed {
		logic       valid;
		// bit 0 is the low halfword
		logic [1:0] any;
		// set where the break goes to debug mode
		logic [1:0] d_mode;
	} hw_break_t;

endpackage

// ==== triggers/trigger_regs.sv ====
// Trigger configuration registers behind tselect, tdata1, tdata2, tinfo.
// Writes from outside debug mode to a debug-owned trigger are dropped
// with no exception. dmode is writable from debug mode only.
// Every tdata1/tdata2 write outside debug mode pulses flush in the next
// cycle so that fetches already in flight see the new setup.
// Reads are combinational from csr.addr.

`timescale 1ns/100ps

module trigger_regs
	import trig_csr_pkg::*;
	import trig_fetch_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n,

	// csr port from execute
	input  csr_req_t                     csr,
	input  priv_e                        x_priv,
	output logic [W_DATA-1:0]            cfg_rdata,

	// live configuration to the matcher
	output trig_cfg_t [N_TRIGGERS-1:0]   trig_cfg,

	// prefetch flush request
	output logic                         flush
);

	// ----------------------------------------------------------
	// selected trigger

	logic [W_TSELECT-1:0] tselect;
	logic                 sel_ok;
	trig_cfg_t            sel_cfg;
	logic                 x_d_mode;

	// tselect may point past the last trigger if N_TRIGGERS is not a power of 2
	assign sel_ok = (tselect < N_TRIGGERS);
	assign sel_cfg = trig_cfg[tselect];
	assign x_d_mode = (x_priv == PRIV_D);

	// ----------------------------------------------------------
	// write decode

	logic wr_tdata;
	logic wr_allowed;
	logic flush_wr;

	assign wr_tdata = csr.wen && (csr.addr == CSR_TDATA1 || csr.addr == CSR_TDATA2);

	// debug-owned triggers ignore writes from m and u mode
	assign wr_allowed = sel_ok && !(sel_cfg.dmode && !x_d_mode);

	// flush even when the write itself was dropped
	assign flush_wr = wr_tdata && !x_d_mode;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tselect <= '0;
			trig_cfg <= '0;
			flush <= 1'b0;
		end else begin
			flush <= flush_wr;
			// tselect always accepts, upper bits dropped
			if (csr.wen && csr.addr == CSR_TSELECT) begin
				tselect <= csr.wdata[W_TSELECT-1:0];
			end
			if (csr.wen && wr_allowed && csr.addr == CSR_TDATA1) begin
				// ownership moves only under debug mode
				if (x_d_mode) begin
					trig_cfg[tselect].dmode <= csr.wdata[TD1_DMODE];
				end
				trig_cfg[tselect].action <= csr.wdata[TD1_ACTION];
				trig_cfg[tselect].m <= csr.wdata[TD1_M];
				trig_cfg[tselect].u <= csr.wdata[TD1_U];
				trig_cfg[tselect].execute <= csr.wdata[TD1_EXECUTE];
			end
			if (csr.wen && wr_allowed && csr.addr == CSR_TDATA2) begin
				trig_cfg[tselect].tdata2 <= csr.wdata;
			end
		end
	end

	// ----------------------------------------------------------
	// read mux

	always_comb begin
		cfg_rdata = '0;
		case (csr.addr)
			CSR_TSELECT: begin
				cfg_rdata[W_TSELECT-1:0] = tselect;
			end
			CSR_TDATA1: begin
				// nonexistent trigger reads as type 0, all zero
				if (sel_ok) begin
					// type 2, address match
					cfg_rdata[TD1_TYPE_LSB +: 4] = 4'd2;
					cfg_rdata[TD1_DMODE] = sel_cfg.dmode;
					cfg_rdata[TD1_ACTION] = sel_cfg.action;
					cfg_rdata[TD1_M] = sel_cfg.m;
					cfg_rdata[TD1_U] = sel_cfg.u;
					cfg_rdata[TD1_EXECUTE] = sel_cfg.execute;
					// maskmax, hit, select, timing, chain, match, s, load, store stay 0
				end
			end
			CSR_TDATA2: begin
				if (sel_ok) begin
					cfg_rdata = sel_cfg.tdata2;
				end
			end
			CSR_TINFO: begin
				cfg_rdata = sel_ok ? TINFO_MCONTROL : TINFO_NONE;
			end
			default: begin
				cfg_rdata = '0;
			end
		endcase
	end

	// ----------------------------------------------------------
	// checks

	// back-to-back flush needs a non-debug tdata1/tdata2 write on the csr port
	// in each earlier cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		flush && $past(flush) |->
			$past(csr.wen && csr.addr inside {CSR_TDATA1, CSR_TDATA2} &&
				x_priv != PRIV_D, 1) &&
			$past(csr.wen && csr.addr inside {CSR_TDATA1, CSR_TDATA2} &&
				x_priv != PRIV_D, 2));

	for (genvar i = 0; i < N_TRIGGERS; i++) begin : g_dmode_chk
		// debug ownership can only be taken from debug mode
		assert property (@(posedge clk) disable iff (!rst_n)
			$rose(trig_cfg[i].dmode) |-> $past(x_priv) == PRIV_D);
	end

endmodule

// ==== triggers/trigger_match.sv ====
// Execute-address comparison against all triggers.
// The address is compared in the fetch address phase and the result is
// registered, so flags line up with the fetch data one cycle later.
// Each trigger steers its hit to one halfword using tdata2 bit 1.

`timescale 1ns/100ps

module trigger_match
	import trig_csr_pkg::*;
	import trig_fetch_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n,

	input  fetch_req_t                   fetch,
	input  trig_cfg_t [N_TRIGGERS-1:0]   trig_cfg,
	// global enable for breaks to m-mode
	input  logic                         trig_m_en,

	output hw_break_t                    flags,
	output logic [W_ADDR-1:0]            flags_addr
);

	logic [N_TRIGGERS-1:0] trig_en;
	logic [N_TRIGGERS-1:0] trig_hit;
	logic [N_TRIGGERS-1:0] want_d;
	logic [N_TRIGGERS-1:0] want_m;
	logic [1:0]            hw_any;
	logic [1:0]            hw_d;

	// ----------------------------------------------------------
	// per-trigger compare

	always_comb begin
		hw_any = '0;
		hw_d = '0;
		for (int i = 0; i < N_TRIGGERS; i++) begin
			// no triggers fire on debug-mode fetches
			trig_en[i] = trig_cfg[i].execute && (
				(fetch.priv == PRIV_M && trig_cfg[i].m) ||
				(fetch.priv == PRIV_U && trig_cfg[i].u));
			trig_hit[i] = trig_en[i] &&
				fetch.addr == {trig_cfg[i].tdata2[W_ADDR-1:2], 2'b00};
			// d-mode break needs the trigger owned by debug mode
			want_d[i] = trig_hit[i] && trig_cfg[i].action && trig_cfg[i].dmode;
			want_m[i] = trig_hit[i] && !trig_cfg[i].action && trig_m_en;
			// fold into the halfword chosen by tdata2[1]
			hw_any[trig_cfg[i].tdata2[1]] = hw_any[trig_cfg[i].tdata2[1]] |
				want_d[i] | want_m[i];
			hw_d[trig_cfg[i].tdata2[1]] = hw_d[trig_cfg[i].tdata2[1]] | want_d[i];
		end
	end

	// ----------------------------------------------------------
	// flag register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			flags.valid <= fetch.valid;
			// idle cycles carry no flags
			flags.any <= fetch.valid ? hw_any : 2'b00;
			flags.d_mode <= fetch.valid ? hw_d : 2'b00;
		end
	end

	// address rides along for the resolver
	always_ff @(posedge clk) begin
		if (fetch.valid) begin
			flags_addr <= fetch.addr;
		end
	end

	// a debug-mode break is always also a break
	assert property (@(posedge clk) disable iff (!rst_n)
		flags.valid |-> (flags.d_mode & ~flags.any) == 2'b00);

endmodule

// ==== logic/break_resolve.sv ====
// Turns per-halfword break flags into a single request.
// instr_start comes with the fetch data, one cycle after the address,
// and marks halfwords where an instruction begins. Only a flag on such a
// halfword counts, which gives exact-match breakpoints.
// Lowest halfword wins when both qualify.

`timescale 1ns/100ps

module break_resolve
	import trig_fetch_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	input  hw_break_t         flags,
	input  logic [W_ADDR-1:0] flags_addr,
	input  logic [1:0]        instr_start,

	output logic              break_m,
	output logic              break_d,
	output logic [W_ADDR-1:0] break_addr
);

	logic [1:0] hw_take;
	logic       take;
	logic       hw_sel;

	// ----------------------------------------------------------
	// halfword pick

	// flagged halfwords that start an instruction
	assign hw_take = flags.any & instr_start;
	assign take = flags.valid && (|hw_take);
	// hw1 only if hw0 does not qualify
	assign hw_sel = !hw_take[0];

	// ----------------------------------------------------------
	// request register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			break_m <= 1'b0;
			break_d <= 1'b0;
		end else begin
			break_d <= take && flags.d_mode[hw_sel];
			break_m <= take && !flags.d_mode[hw_sel];
		end
	end

	// halfword address of the break, held between requests
	always_ff @(posedge clk) begin
		if (take) begin
			break_addr <= flags_addr + W_ADDR'({hw_sel, 1'b0});
		end
	end

	// m-mode and d-mode requests are exclusive
	assert property (@(posedge clk) disable iff (!rst_n)
		!(break_m && break_d));

endmodule

// ==== logic/trigger_subsys.sv ====
// Breakpoint trigger subsystem top.
// Requests come out two cycles after the fetch address. The core must
// take flush after any tdata1/tdata2 write outside debug mode, before
// it trusts fetches already in flight.

`timescale 1ns/100ps

module trigger_subsys
	import trig_csr_pkg::*;
	import trig_fetch_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	// csr access from execute
	input  csr_req_t          csr,
	input  priv_e             x_priv,
	output logic [W_DATA-1:0] cfg_rdata,
	output logic              flush,

	// fetch side
	input  logic              trig_m_en,
	input  fetch_req_t        fetch,
	input  logic [1:0]        instr_start,

	// break requests
	output logic              break_m,
	output logic              break_d,
	output logic [W_ADDR-1:0] break_addr
);

	trig_cfg_t [N_TRIGGERS-1:0] trig_cfg;
	hw_break_t                  flags;
	logic [W_ADDR-1:0]          flags_addr;

	trigger_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.csr       (csr),
		.x_priv    (x_priv),
		.cfg_rdata (cfg_rdata),
		.trig_cfg  (trig_cfg),
		.flush     (flush)
	);

	trigger_match u_match (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch      (fetch),
		.trig_cfg   (trig_cfg),
		.trig_m_en  (trig_m_en),
		.flags      (flags),
		.flags_addr (flags_addr)
	);

	break_resolve u_resolve (
		.clk         (clk),
		.rst_n       (rst_n),
		.flags       (flags),
		.flags_addr  (flags_addr),
		.instr_start (instr_start),
		.break_m     (break_m),
		.break_d     (break_d),
		.break_addr  (break_addr)
	);

endmodule

// ==== tb/tb_trigger_subsys.sv ====
// Testbench for the breakpoint trigger subsystem.
// Inputs change on the falling clock edge and all checks are concurrent
// assertions sampled on the rising edge against a shadow model.
// The model assumes no fetch is issued in the same cycle as a CSR write.
// The first failed check stops the run.

`timescale 1ns/100ps

module tb_trigger_subsys
	import trig_csr_pkg::*;
	import trig_fetch_pkg::*;
();

	// ----------------------------------------------------------
	// run length and bit masks

	localparam int N_RANDOM = 40;
	// directed tests plus reset, rounded up
	localparam int DIRECTED_CYCLES = 140;
	localparam int STIM_CYCLES = 8 + DIRECTED_CYCLES + N_RANDOM;
	localparam int MARGIN_CYCLES = 20;

	localparam logic [W_DATA-1:0] BIT_EXE = 32'd1 << TD1_EXECUTE;
	localparam logic [W_DATA-1:0] BIT_M   = 32'd1 << TD1_M;
	localparam logic [W_DATA-1:0] BIT_U   = 32'd1 << TD1_U;
	localparam logic [W_DATA-1:0] BIT_ACT = 32'd1 << TD1_ACTION;
	localparam logic [W_DATA-1:0] BIT_DM  = 32'd1 << TD1_DMODE;

	// expected request for one query
	typedef struct packed {
		logic              m;
		logic              d;
		logic [W_ADDR-1:0] addr;
	} exp_brk_t;

	// DUT ports
	logic              clk;
	logic              rst_n;
	csr_req_t          csr;
	priv_e             x_priv;
	logic [W_DATA-1:0] cfg_rdata;
	logic              flush;
	logic              trig_m_en;
	fetch_req_t        fetch;
	logic [1:0]        instr_start;
	logic              break_m;
	logic              break_d;
	logic [W_ADDR-1:0] break_addr;

	// shadow model of the trigger bank
	trig_cfg_t            model_cfg [N_TRIGGERS];
	logic [W_TSELECT-1:0] model_tsel;

	// expectations set with the stimulus
	logic [W_DATA-1:0] exp_rdata = '0;
	logic              chk_rdata = 1'b0;
	logic              exp_flush = 1'b0;
	exp_brk_t          exp_now = '0;
	// instr_start goes out one cycle after its fetch
	logic [1:0]        start_next = 2'b00;

	// delay line, two queries in flight
	logic     flush_q = 1'b0;
	exp_brk_t exp_q1 = '0;
	exp_brk_t exp_q2 = '0;

	int fail_count = 0;

	trigger_subsys DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.csr         (csr),
		.x_priv      (x_priv),
		.cfg_rdata   (cfg_rdata),
		.flush       (flush),
		.trig_m_en   (trig_m_en),
		.fetch       (fetch),
		.instr_start (instr_start),
		.break_m     (break_m),
		.break_d     (break_d),
		.break_addr  (break_addr)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		flush_q <= exp_flush;
		exp_q1 <= exp_now;
		exp_q2 <= exp_q1;
	end

	// ----------------------------------------------------------
	// reference rules

	function automatic logic [W_DATA-1:0] expected_read(input logic [11:0] addr);
		logic [W_DATA-1:0] v;
		trig_cfg_t         c;
		v = '0;
		c = model_cfg[model_tsel];
		case (addr)
			CSR_TSELECT: v = W_DATA'(model_tsel);
			CSR_TDATA1: begin
				// mcontrol, type 2
				v[TD1_TYPE_LSB +: 4] = 4'd2;
				v[TD1_DMODE] = c.dmode;
				v[TD1_ACTION] = c.action;
				v[TD1_M] = c.m;
				v[TD1_U] = c.u;
				v[TD1_EXECUTE] = c.execute;
			end
			CSR_TDATA2: v = c.tdata2;
			CSR_TINFO: v = TINFO_MCONTROL;
			default: v = '0;
		endcase
		return v;
	endfunction

	function automatic exp_brk_t expected_break(input logic [W_ADDR-1:0] addr,
		input priv_e priv, input logic m_en, input logic [1:0] start);
		exp_brk_t  r;
		trig_cfg_t c;
		logic [1:0] hw_any;
		logic [1:0] hw_dm;
		logic [1:0] take;
		logic       en;
		logic       hit;
		logic       hw;
		r = '0;
		hw_any = '0;
		hw_dm = '0;
		for (int i = 0; i < N_TRIGGERS; i++) begin
			c = model_cfg[i];
			// debug-mode fetches never enable a trigger
			en = c.execute && ((priv == PRIV_M && c.m) || (priv == PRIV_U && c.u));
			hit = en && (addr[W_ADDR-1:2] == c.tdata2[W_ADDR-1:2]);
			hw = c.tdata2[1];
			if (hit && c.action && c.dmode) begin
				hw_any[hw] = 1'b1;
				hw_dm[hw] = 1'b1;
			end else if (hit && !c.action && m_en) begin
				hw_any[hw] = 1'b1;
			end
		end
		// only halfwords that start an instruction, low one first
		take = hw_any & start;
		if (take[0]) begin
			r.d = hw_dm[0];
			r.m = !hw_dm[0];
			r.addr = addr;
		end else if (take[1]) begin
			r.d = hw_dm[1];
			r.m = !hw_dm[1];
			r.addr = addr + 32'd2;
		end
		return r;
	endfunction

	function automatic priv_e rand_priv();
		case ($urandom % 3)
			0: return PRIV_U;
			1: return PRIV_M;
			default: return PRIV_D;
		endcase
	endfunction

	// ----------------------------------------------------------
	// stimulus tasks

	task automatic fail_stop();
		fail_count++;
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	// one cycle with every input idle
	task automatic next_cycle();
		@(negedge clk);
		csr = '0;
		x_priv = PRIV_M;
		fetch = '0;
		instr_start = start_next;
		start_next = 2'b00;
		exp_now = '0;
		exp_flush = 1'b0;
		chk_rdata = 1'b0;
	endtask

	task automatic csr_write(input logic [11:0] addr, input logic [W_DATA-1:0] data,
		input priv_e priv);
		trig_cfg_t c;
		logic      allowed;
		next_cycle();
		csr.addr = addr;
		csr.wen = 1'b1;
		csr.wdata = data;
		x_priv = priv;
		c = model_cfg[model_tsel];
		// debug-owned triggers ignore m and u writes
		allowed = !(c.dmode && priv != PRIV_D);
		if (addr == CSR_TSELECT) begin
			model_tsel = data[W_TSELECT-1:0];
		end else if (addr == CSR_TDATA1 && allowed) begin
			if (priv == PRIV_D) begin
				c.dmode = data[TD1_DMODE];
			end
			c.action = data[TD1_ACTION];
			c.m = data[TD1_M];
			c.u = data[TD1_U];
			c.execute = data[TD1_EXECUTE];
			model_cfg[model_tsel] = c;
		end else if (addr == CSR_TDATA2 && allowed) begin
			c.tdata2 = data;
			model_cfg[model_tsel] = c;
		end
		// flush even for a dropped write
		exp_flush = (addr == CSR_TDATA1 || addr == CSR_TDATA2) && priv != PRIV_D;
	endtask

	task automatic csr_read(input logic [11:0] addr);
		next_cycle();
		csr.addr = addr;
		exp_rdata = expected_read(addr);
		chk_rdata = 1'b1;
	endtask

	task automatic program_trigger(input int idx, input logic [W_DATA-1:0] td1,
		input logic [W_DATA-1:0] td2, input priv_e priv);
		csr_write(CSR_TSELECT, W_DATA'(idx), priv);
		csr_write(CSR_TDATA1, td1, priv);
		csr_write(CSR_TDATA2, td2, priv);
	endtask

	task automatic query(input logic [W_ADDR-1:0] addr, input priv_e priv,
		input logic m_en, input logic [1:0] start);
		next_cycle();
		fetch.valid = 1'b1;
		fetch.addr = addr;
		fetch.priv = priv;
		trig_m_en = m_en;
		start_next = start;
		exp_now = expected_break(addr, priv, m_en, start);
	endtask

	// ----------------------------------------------------------
	// checks

	assert property (@(posedge clk) disable iff (!rst_n)
		chk_rdata |-> cfg_rdata == exp_rdata)
	else begin
		$display("FAIL cfg_rdata expected %h got %h", $sampled(exp_rdata),
			$sampled(cfg_rdata));
		fail_stop();
	end

	assert property (@(posedge clk) disable iff (!rst_n) flush == flush_q)
	else begin
		$display("FAIL flush expected %h got %h", $sampled(flush_q), $sampled(flush));
		fail_stop();
	end

	assert property (@(posedge clk) disable iff (!rst_n) break_m == exp_q2.m)
	else begin
		$display("FAIL break_m expected %h got %h", $sampled(exp_q2.m),
			$sampled(break_m));
		fail_stop();
	end

	assert property (@(posedge clk) disable iff (!rst_n) break_d == exp_q2.d)
	else begin
		$display("FAIL break_d expected %h got %h", $sampled(exp_q2.d),
			$sampled(break_d));
		fail_stop();
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(exp_q2.m || exp_q2.d) |-> break_addr == exp_q2.addr)
	else begin
		$display("FAIL break_addr expected %h got %h", $sampled(exp_q2.addr),
			$sampled(break_addr));
		fail_stop();
	end

	// watchdog
	initial begin
		#((STIM_CYCLES + MARGIN_CYCLES) * 100);
		$display("timeout: the tests did not finish in %0d cycles",
			STIM_CYCLES + MARGIN_CYCLES);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	// ----------------------------------------------------------
	// test sequence

	initial begin
		logic [W_ADDR-1:0] trig_addr [N_TRIGGERS];
		logic [W_ADDR-1:0] a;
		logic [W_ADDR-1:0] base_b;
		int unsigned       pick;
		void'($urandom(50410));
		clk = 1'b0;
		rst_n = 1'b0;
		csr = '0;
		x_priv = PRIV_M;
		trig_m_en = 1'b0;
		fetch = '0;
		instr_start = 2'b00;
		model_tsel = '0;
		for (int i = 0; i < N_TRIGGERS; i++) begin
			model_cfg[i] = '0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// readback, dmode cannot be set from m mode
		for (int i = 0; i < N_TRIGGERS; i++) begin
			csr_write(CSR_TSELECT, W_DATA'(i), PRIV_M);
			csr_read(CSR_TSELECT);
			csr_write(CSR_TDATA1, 32'hffff_ffff, PRIV_M);
			csr_read(CSR_TDATA1);
			csr_write(CSR_TDATA2, $urandom, PRIV_M);
			csr_read(CSR_TDATA2);
			csr_read(CSR_TINFO);
		end
		// tselect keeps its low bits only
		csr_write(CSR_TSELECT, 32'hffff_fffe, PRIV_M);
		csr_read(CSR_TSELECT);
		// unused address in the trigger range
		csr_read(12'h7a3);

		// debug ownership of trigger 1
		csr_write(CSR_TSELECT, 32'd1, PRIV_D);
		csr_write(CSR_TDATA1, BIT_DM | BIT_ACT | BIT_EXE | BIT_M, PRIV_D);
		csr_write(CSR_TDATA2, 32'h1234_5678, PRIV_D);
		csr_read(CSR_TDATA1);
		csr_write(CSR_TDATA1, 32'h0, PRIV_M);
		csr_read(CSR_TDATA1);
		csr_write(CSR_TDATA2, 32'hdead_beef, PRIV_M);
		csr_read(CSR_TDATA2);
		csr_write(CSR_TDATA1, BIT_EXE | BIT_M | BIT_U, PRIV_D);
		csr_read(CSR_TDATA1);
		csr_write(CSR_TDATA2, 32'hcafe_f00c, PRIV_D);
		csr_read(CSR_TDATA2);

		// m-mode breaks on random addresses
		for (int i = 0; i < N_TRIGGERS; i++) begin
			trig_addr[i] = $urandom;
			program_trigger(i, BIT_EXE | BIT_M | BIT_U, trig_addr[i], PRIV_M);
		end
		for (int i = 0; i < N_TRIGGERS; i++) begin
			a = {trig_addr[i][W_ADDR-1:2], 2'b00};
			query(a, PRIV_M, 1'b1, 2'b01 << trig_addr[i][1]);
		end
		repeat (3) next_cycle();

		// gating, trigger 0 with u clear
		program_trigger(0, BIT_EXE | BIT_M, trig_addr[0], PRIV_M);
		a = {trig_addr[0][W_ADDR-1:2], 2'b00};
		query(a, PRIV_U, 1'b1, 2'b01 << trig_addr[0][1]);
		query(a, PRIV_D, 1'b1, 2'b01 << trig_addr[0][1]);
		query(a, PRIV_M, 1'b0, 2'b01 << trig_addr[0][1]);
		query(a ^ 32'h100, PRIV_M, 1'b1, 2'b11);
		query(a, PRIV_M, 1'b1, 2'b10 >> trig_addr[0][1]);
		repeat (3) next_cycle();

		// d-mode on halfword 0, m-mode on halfword 1 of the same word
		base_b = $urandom & 32'hffff_fffc;
		program_trigger(2, BIT_DM | BIT_ACT | BIT_EXE | BIT_M, base_b, PRIV_D);
		program_trigger(3, BIT_EXE | BIT_M, base_b | 32'd2, PRIV_M);
		query(base_b, PRIV_M, 1'b1, 2'b01);
		query(base_b, PRIV_M, 1'b1, 2'b11);
		query(base_b, PRIV_M, 1'b1, 2'b10);
		query(base_b, PRIV_M, 1'b0, 2'b11);
		repeat (3) next_cycle();

		// random back-to-back queries
		for (int n = 0; n < N_RANDOM; n++) begin
			pick = $urandom % 3;
			if (pick == 0) begin
				a = trig_addr[$urandom % N_TRIGGERS] & 32'hffff_fffc;
			end else if (pick == 1) begin
				a = base_b;
			end else begin
				a = $urandom & 32'hffff_fffc;
			end
			query(a, rand_priv(), 1'(($urandom % 2)), 2'(($urandom % 4)));
		end
		repeat (3) next_cycle();

		if (fail_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "errors were found");
		end
	end

endmodule

// ==== verilog.f ====
common/trig_csr_pkg.sv
common/trig_fetch_pkg.sv
triggers/trigger_regs.sv
triggers/trigger_match.sv
logic/break_resolve.sv
logic/trigger_subsys.sv
tb/tb_trigger_subsys.sv
